// File: files.f
+incdir+design
design/rv_pkg.sv
design/rv_rf_read_if.sv
design/rv_regfile.sv
design/rv_stage_reg.sv
design/rv_decode.sv
design/rv_execute.sv
design/rv_writeback.sv
design/rv_exec_core.sv
test/tb_rv_exec_core.sv

// File: Bender.yml
package:
  name: rv_exec_core

sources:
  - include_dirs:
      - design
    files:
      - design/rv_pkg.sv
      - design/rv_rf_read_if.sv
      - design/rv_regfile.sv
      - design/rv_stage_reg.sv
      - design/rv_decode.sv
      - design/rv_execute.sv
      - design/rv_writeback.sv
      - design/rv_exec_core.sv
  - target: test
    include_dirs:
      - design
    files:
      - test/tb_rv_exec_core.sv

// File: test/tb_rv_exec_core.sv
`default_nettype none

`include "rv_macros.svh"

module tb_rv_exec_core
    import rv_pkg::*;
;

    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam int n_insts     = 103;
    localparam int cycle_limit = 10 * n_insts + 200;

    logic clk, rst, in_valid, in_ready, out_ready, out_valid;
    logic [31:0] in_inst;
    logic [`RV_XLEN-1:0] in_pc, out_pc, out_value, out_next_pc;
    logic [`RV_REG_AW-1:0] out_rd;
    logic out_rd_wen, out_branch_taken, out_illegal;

    logic [`RV_XLEN-1:0] regs [32];  // architectural state in program order
    exe_pkt_t exp_q [$];
    logic [`RV_XLEN-1:0] pc_in;
    string test_name;
    int errors, checks, cycles;
    logic bp_on;

    rv_exec_core dut_i (
        .clk(clk), .rst(rst), .in_valid(in_valid), .in_inst(in_inst), .in_pc(in_pc),
        .in_ready(in_ready), .out_valid(out_valid), .out_pc(out_pc), .out_rd(out_rd),
        .out_value(out_value), .out_rd_wen(out_rd_wen), .out_branch_taken(out_branch_taken),
        .out_next_pc(out_next_pc), .out_illegal(out_illegal), .out_ready(out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    // expected result record, updates the register model
    function automatic exe_pkt_t model_exec(input logic [31:0] inst, input logic [31:0] pc);
        exe_pkt_t r;
        logic [31:0] a, b, imm_i, imm_b, imm_j;
        logic [6:0] f7;
        logic [2:0] f3;
        logic wr;
        f3 = inst[14:12];
        f7 = inst[31:25];
        a = regs[inst[19:15]];
        b = regs[inst[24:20]];
        imm_i = {{20{inst[31]}}, inst[31:20]};
        imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        r = '0;
        r.pc = pc;
        r.rd = inst[11:7];
        r.next_pc = pc + 32'd4;
        wr = 1'b1;
        case (inst[6:0])
            7'b0110111: r.value = {inst[31:12], 12'b0};
            7'b0010111: r.value = pc + {inst[31:12], 12'b0};
            7'b1101111: begin
                r.value = pc + 32'd4;
                r.branch_taken = 1'b1;
                r.next_pc = pc + imm_j;
            end
            opc_jalr: begin
                r.illegal = (f3 != 3'd0);
                r.value = pc + 32'd4;
                r.branch_taken = !r.illegal;
                if (!r.illegal) r.next_pc = (a + imm_i) & ~32'd1;
            end
            7'b1100011: begin
                wr = 1'b0;
                r.illegal = (f3 == 3'd2) || (f3 == 3'd3);
                r.branch_taken = !r.illegal && branch_ref(f3, a, b);
                if (r.branch_taken) r.next_pc = pc + imm_b;
            end
            opc_op_imm: begin
                r.illegal = (f3 == 3'd1 && f7 != 7'h00)
                         || (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20);
                r.value = alu_ref(f3, f3 == 3'd5 && f7[5], a, imm_i);
            end
            7'b0110011: begin
                r.illegal = f7 != 7'h00 && !(f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
                r.value = alu_ref(f3, f7[5], a, b);
            end
            default: r.illegal = 1'b1;  // load, store, system, unknown
        endcase
        if (r.illegal) begin
            wr = 1'b0;
            r.value = '0;
        end
        r.rd_wen = wr && r.rd != '0;
        if (r.rd_wen) regs[r.rd] = r.value;
        return r;
    endfunction

    task automatic check_field(input string field, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("CHECK FAILED %s %s: expected %h, actual %h", test_name, field, exp, act);
        end
    endtask

    task automatic send(input logic [31:0] inst);
        exp_q.push_back(model_exec(inst, pc_in));
        in_valid <= 1'b1;
        in_inst  <= inst;
        in_pc    <= pc_in;
        pc_in = pc_in + 32'd4;
        do @(posedge clk); while (!in_ready);
    endtask

    task automatic drain();
        in_valid <= 1'b0;
        while (exp_q.size() != 0) @(posedge clk);
        @(posedge clk);
    endtask

    // low through reset, random under back-pressure
    always @(posedge clk) begin
        if (rst) begin
            out_ready <= 1'b0;
        end else begin
            out_ready <= bp_on ? 1'($urandom_range(1, 0)) : 1'b1;
        end
    end

    // result monitor and hold check
    always @(posedge clk) begin
        exe_pkt_t got, exp;
        logic held;
        exe_pkt_t held_rec;
        got = {out_pc, out_rd, out_value, out_rd_wen, out_branch_taken, out_next_pc,
               out_illegal};
        if (rst) begin
            held = 1'b0;
        end else begin
            if (held) begin
                assert (out_valid && got == held_rec) else begin
                    errors++;
                    $display("%s: result changed while out_ready was low", test_name);
                end
            end
            held = out_valid && !out_ready;
            held_rec = got;
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("%s: result arrived with nothing outstanding", test_name);
                end else begin
                    exp = exp_q.pop_front();
                    check_field("pc", exp.pc, got.pc);
                    check_field("rd", 32'(exp.rd), 32'(got.rd));
                    check_field("rd_wen", 32'(exp.rd_wen), 32'(got.rd_wen));
                    check_field("branch_taken", 32'(exp.branch_taken), 32'(got.branch_taken));
                    check_field("next_pc", exp.next_pc, got.next_pc);
                    check_field("illegal", 32'(exp.illegal), 32'(got.illegal));
                    if (exp.rd_wen) check_field("value", exp.value, got.value);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout after %0d cycles, %0d results missing", cycles, exp_q.size());
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    task automatic test_reset();
        test_name = "test_reset";
        @(posedge clk);
        check_field("out_valid", 32'd0, 32'(out_valid));
        check_field("in_ready", 32'd1, 32'(in_ready));
    endtask

    task automatic test_alu();
        logic [31:0] rnd;
        test_name = "test_alu";
        for (int r = 1; r <= 8; r++) begin
            rnd = $urandom;
            send(u_type(rnd[19:0], 5'(r), 7'b0110111));  // lui
            send(i_type(rnd[31:20], 5'(r), 3'd0, 5'(r), opc_op_imm));
        end
        rnd = $urandom;
        send(u_type(rnd[19:0], 5'd9, 7'b0010111));  // auipc
        for (int f = 0; f < 8; f++) begin
            rnd = $urandom;
            if (f == 1 || f == 5) rnd[11:5] = 7'h00;
            send(i_type(rnd[11:0], 5'($urandom_range(8, 1)), 3'(f),
                        5'($urandom_range(15, 10)), opc_op_imm));
            if (f == 5) send(i_type({7'h20, rnd[4:0]}, 5'($urandom_range(8, 1)), 3'd5,
                                    5'($urandom_range(15, 10)), opc_op_imm));
        end
        for (int f = 0; f < 8; f++) begin
            send(r_type(7'h00, 5'($urandom_range(8, 1)), 5'($urandom_range(8, 1)), 3'(f),
                        5'($urandom_range(15, 10))));
            if (f == 0 || f == 5) send(r_type(7'h20, 5'($urandom_range(8, 1)),
                                              5'($urandom_range(8, 1)), 3'(f),
                                              5'($urandom_range(15, 10))));
        end
        send(i_type(12'h005, 5'd1, 3'd0, 5'd0, opc_op_imm));  // x0 stays zero
        send(r_type(7'h00, 5'd2, 5'd1, 3'd0, 5'd0));
        drain();
    endtask

    task automatic test_dependence();
        test_name = "test_dependence";
        send(i_type(12'h001, 5'd0, 3'd0, 5'd16, opc_op_imm));
        repeat (8) send(r_type(7'h00, 5'd16, 5'd16, 3'd0, 5'd16));
        send(i_type(12'h003, 5'd16, 3'd0, 5'd17, opc_op_imm));
        send(r_type(7'h20, 5'd16, 5'd17, 3'd0, 5'd18));
        drain();
    endtask

    task automatic test_control();
        logic [4:0] pa [3] = '{5'd20, 5'd20, 5'd21};
        logic [4:0] pb [3] = '{5'd22, 5'd21, 5'd20};
        logic [31:0] rnd;
        test_name = "test_control";
        send(i_type(12'h005, 5'd0, 3'd0, 5'd20, opc_op_imm));
        send(i_type(12'hffd, 5'd0, 3'd0, 5'd21, opc_op_imm));  // -3
        send(i_type(12'h005, 5'd0, 3'd0, 5'd22, opc_op_imm));
        for (int f = 0; f < 8; f++) begin
            if (f == 2 || f == 3) continue;
            for (int p = 0; p < 3; p++) begin
                rnd = $urandom;
                send(b_type({rnd[12:1], 1'b0}, pb[p], pa[p], 3'(f)));
            end
        end
        rnd = $urandom;
        send(j_type({rnd[20:1], 1'b0}, 5'd23));
        send(i_type(12'h0a2, 5'd20, 3'd0, 5'd24, opc_jalr));  // odd target, bit 0 cleared
        send(i_type(rnd[31:20], 5'd21, 3'd0, 5'd25, opc_jalr));
        drain();
    endtask

    task automatic test_backpressure();
        logic [31:0] rnd;
        logic [2:0] f3;
        test_name = "test_backpressure";
        bp_on <= 1'b1;
        repeat (20) begin
            rnd = $urandom;
            f3 = rnd[2:0];
            send(r_type((rnd[3] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00,
                        5'($urandom_range(15, 1)), 5'($urandom_range(15, 1)), f3,
                        5'($urandom_range(15, 10))));
        end
        drain();
        bp_on <= 1'b0;
    endtask

    task automatic test_illegal();
        test_name = "test_illegal";
        send(i_type(12'h123, 5'd0, 3'd0, 5'd26, opc_op_imm));
        send(i_type(12'h456, 5'd0, 3'd0, 5'd27, opc_op_imm));
        send(i_type(12'h789, 5'd0, 3'd0, 5'd28, opc_op_imm));
        send(i_type(12'h010, 5'd1, 3'b010, 5'd26, 7'b0000011));  // lw
        send({7'h00, 5'd26, 5'd2, 3'b010, 5'd4, 7'b0100011});     // sw
        send(i_type(12'h300, 5'd1, 3'b001, 5'd27, 7'b1110011));  // csrrw
        send(32'h0000_0073);                                     // ecall
        send(i_type(12'h000, 5'd1, 3'd0, 5'd28, 7'b1111111));
        send(i_type(12'h000, 5'd26, 3'd0, 5'd29, opc_op_imm));   // reads back x26
        send(r_type(7'h00, 5'd28, 5'd27, 3'd0, 5'd30));
        drain();
    endtask

    initial begin
        void'($urandom(32'h992c));
        rst = 1'b1;
        in_valid = 1'b0;
        in_inst = '0;
        in_pc = '0;
        out_ready = 1'b0;
        bp_on = 1'b0;
        pc_in = 32'h0000_1000;
        errors = 0;
        checks = 0;
        cycles = 0;
        test_name = "reset";
        for (int i = 0; i < 32; i++) regs[i] = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        test_reset();
        test_alu();
        test_dependence();
        test_control();
        test_backpressure();
        test_illegal();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: design/rv_exec_core.sv
`default_nettype none

`include "rv_macros.svh"

module rv_exec_core
    import rv_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    input  logic [31:0]           in_inst,
    input  logic [`RV_XLEN-1:0]   in_pc,
    output logic                  in_ready,
    output logic                  out_valid,
    output logic [`RV_XLEN-1:0]   out_pc,
    output logic [`RV_REG_AW-1:0] out_rd,
    output logic [`RV_XLEN-1:0]   out_value,
    output logic                  out_rd_wen,
    output logic                  out_branch_taken,
    output logic [`RV_XLEN-1:0]   out_next_pc,
    output logic                  out_illegal,
    input  logic                  out_ready
);

    rv_rf_read_if rf_rd ();

    logic dec_valid, dec_ready, dq_valid, dq_ready;
    logic exe_ready, eq_valid, eq_ready;
    logic rf_wen;
    logic [`RV_REG_AW-1:0] rf_waddr;
    logic [`RV_XLEN-1:0]   rf_wdata;
    dec_pkt_t dec_pkt, dq_pkt;
    exe_pkt_t exe_pkt, eq_pkt;

    // destinations still on their way to the register file
    wire pend_a_valid = dq_valid && (dq_pkt.wb_sel != wb_none);
    wire pend_b_valid = eq_valid && eq_pkt.rd_wen;

    rv_regfile regfile_i (
        .clk(clk), .rst(rst), .rd(rf_rd.bank),
        .wen(rf_wen), .waddr(rf_waddr), .wdata(rf_wdata)
    );

    rv_decode decode_i (
        .in_valid(in_valid), .in_inst(in_inst), .in_pc(in_pc), .in_ready(in_ready),
        .rf(rf_rd.reader),
        .pend_a_valid(pend_a_valid), .pend_a_rd(dq_pkt.rd),
        .pend_b_valid(pend_b_valid), .pend_b_rd(eq_pkt.rd),
        .out_valid(dec_valid), .out_ready(dec_ready), .out_pkt(dec_pkt)
    );

    rv_stage_reg #(.payload_t(dec_pkt_t)) dec_q (
        .clk(clk), .rst(rst),
        .in_valid(dec_valid), .in_ready(dec_ready), .in_data(dec_pkt),
        .out_valid(dq_valid), .out_ready(dq_ready), .out_data(dq_pkt)
    );

    rv_execute execute_i (.in_pkt(dq_pkt), .out_pkt(exe_pkt));

    assign dq_ready = exe_ready;

    rv_stage_reg #(.payload_t(exe_pkt_t)) exe_q (
        .clk(clk), .rst(rst),
        .in_valid(dq_valid), .in_ready(exe_ready), .in_data(exe_pkt),
        .out_valid(eq_valid), .out_ready(eq_ready), .out_data(eq_pkt)
    );

    rv_writeback writeback_i (
        .in_valid(eq_valid), .in_ready(eq_ready), .in_pkt(eq_pkt),
        .rf_wen(rf_wen), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata),
        .out_valid(out_valid), .out_pc(out_pc), .out_rd(out_rd), .out_value(out_value),
        .out_rd_wen(out_rd_wen), .out_branch_taken(out_branch_taken),
        .out_next_pc(out_next_pc), .out_illegal(out_illegal), .out_ready(out_ready)
    );

endmodule

`default_nettype wire

// File: design/rv_writeback.sv
`default_nettype none

`include "rv_macros.svh"

module rv_writeback
    import rv_pkg::*;
(
    input  logic                  in_valid,
    output logic                  in_ready,
    input  exe_pkt_t              in_pkt,
    output logic                  rf_wen,
    output logic [`RV_REG_AW-1:0] rf_waddr,
    output logic [`RV_XLEN-1:0]   rf_wdata,
    output logic                  out_valid,
    output logic [`RV_XLEN-1:0]   out_pc,
    output logic [`RV_REG_AW-1:0] out_rd,
    output logic [`RV_XLEN-1:0]   out_value,
    output logic                  out_rd_wen,
    output logic                  out_branch_taken,
    output logic [`RV_XLEN-1:0]   out_next_pc,
    output logic                  out_illegal,
    input  logic                  out_ready
);

    assign in_ready  = out_ready;
    assign out_valid = in_valid;

    // commit only on the handshake edge
    assign rf_wen   = in_valid && out_ready && in_pkt.rd_wen;
    assign rf_waddr = in_pkt.rd;
    assign rf_wdata = in_pkt.value;

    assign out_pc           = in_pkt.pc;
    assign out_rd           = in_pkt.rd;
    assign out_value        = in_pkt.value;
    assign out_rd_wen       = in_pkt.rd_wen;
    assign out_branch_taken = in_pkt.branch_taken;
    assign out_next_pc      = in_pkt.next_pc;
    assign out_illegal      = in_pkt.illegal;

endmodule

`default_nettype wire

// File: design/rv_execute.sv
`default_nettype none

`include "rv_macros.svh"

module rv_execute
    import rv_pkg::*;
(
    input  dec_pkt_t in_pkt,
    output exe_pkt_t out_pkt
);

    localparam int sh_w = $clog2(`RV_XLEN);

    logic [`RV_XLEN-1:0] op1, op2, sum, alu_res;
    logic [`RV_XLEN-1:0] pc_plus4, target;
    logic [sh_w-1:0]     shamt;
    logic                br_cond, redirect;

    assign op1   = in_pkt.op1;
    assign op2   = in_pkt.op2;
    assign sum   = op1 + op2;
    assign shamt = op2[sh_w-1:0];

    always_comb begin
        alu_res = '0;
        br_cond = 1'b0;
        case (in_pkt.alu_op)
            alu_add:   alu_res = sum;
            alu_sub:   alu_res = op1 - op2;
            alu_and:   alu_res = op1 & op2;
            alu_or:    alu_res = op1 | op2;
            alu_xor:   alu_res = op1 ^ op2;
            alu_sll:   alu_res = op1 << shamt;
            alu_srl:   alu_res = op1 >> shamt;
            alu_sra:   alu_res = $unsigned($signed(op1) >>> shamt);
            alu_slt:   alu_res = {{(`RV_XLEN-1){1'b0}}, $signed(op1) < $signed(op2)};
            alu_sltu:  alu_res = {{(`RV_XLEN-1){1'b0}}, op1 < op2};
            alu_copy2: alu_res = op2;
            br_beq:    br_cond = (op1 == in_pkt.rs2_val);
            br_bne:    br_cond = (op1 != in_pkt.rs2_val);
            br_blt:    br_cond = $signed(op1) < $signed(in_pkt.rs2_val);
            br_bge:    br_cond = $signed(op1) >= $signed(in_pkt.rs2_val);
            br_bltu:   br_cond = op1 < in_pkt.rs2_val;
            br_bgeu:   br_cond = op1 >= in_pkt.rs2_val;
            default:   alu_res = '0;
        endcase
    end

    assign pc_plus4 = in_pkt.pc + `RV_XLEN'd4;
    assign target   = in_pkt.pc + in_pkt.br_off;
    assign redirect = in_pkt.is_jal || in_pkt.is_jalr || (in_pkt.is_branch && br_cond);

    always_comb begin
        out_pkt.pc = in_pkt.pc;
        out_pkt.rd = in_pkt.rd;
        case (in_pkt.wb_sel)
            wb_alu:  out_pkt.value = alu_res;
            wb_link: out_pkt.value = pc_plus4;
            default: out_pkt.value = '0;  // branches and illegal ops
        endcase
        out_pkt.rd_wen       = (in_pkt.wb_sel != wb_none) && (in_pkt.rd != '0)
                               && !in_pkt.illegal;
        out_pkt.branch_taken = redirect;
        if (in_pkt.is_jalr) begin
            out_pkt.next_pc = {sum[`RV_XLEN-1:1], 1'b0};
        end else if (redirect) begin
            out_pkt.next_pc = target;
        end else begin
            out_pkt.next_pc = pc_plus4;
        end
        out_pkt.illegal = in_pkt.illegal;
    end

endmodule

`default_nettype wire

// File: design/rv_decode.sv
`default_nettype none

`include "rv_macros.svh"

module rv_decode
    import rv_pkg::*;
(
    input  logic                  in_valid,
    input  logic [31:0]           in_inst,
    input  logic [`RV_XLEN-1:0]   in_pc,
    output logic                  in_ready,
    rv_rf_read_if.reader          rf,
    input  logic                  pend_a_valid,
    input  logic [`RV_REG_AW-1:0] pend_a_rd,
    input  logic                  pend_b_valid,
    input  logic [`RV_REG_AW-1:0] pend_b_rd,
    output logic                  out_valid,
    input  logic                  out_ready,
    output dec_pkt_t              out_pkt
);

    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_op     = 7'b0110011;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [`RV_REG_AW-1:0] rs1, rs2;
    logic [`RV_XLEN-1:0] imm_i, imm_b, imm_j, imm_u;
    alu_op_e  alu_op;
    op1_sel_e op1_sel;
    op2_sel_e op2_sel;
    wb_sel_e  wb_sel;
    logic use_rs1, use_rs2, is_branch, is_jal, is_jalr, illegal;
    logic stall;

    assign opcode = in_inst[6:0];
    assign funct3 = in_inst[14:12];
    assign funct7 = in_inst[31:25];
    assign rs1    = in_inst[19:15];
    assign rs2    = in_inst[24:20];

    assign imm_i = {{20{in_inst[31]}}, in_inst[31:20]};
    assign imm_b = {{19{in_inst[31]}}, in_inst[31], in_inst[7], in_inst[30:25],
                    in_inst[11:8], 1'b0};
    assign imm_j = {{11{in_inst[31]}}, in_inst[31], in_inst[19:12], in_inst[20],
                    in_inst[30:21], 1'b0};
    assign imm_u = {in_inst[31:12], 12'b0};

    always_comb begin
        alu_op    = alu_add;
        op1_sel   = op1_zero;
        op2_sel   = op2_imi;
        wb_sel    = wb_none;
        use_rs1   = 1'b0;
        use_rs2   = 1'b0;
        is_branch = 1'b0;
        is_jal    = 1'b0;
        is_jalr   = 1'b0;
        illegal   = 1'b0;
        case (opcode)
            opc_lui: begin
                alu_op  = alu_copy2;
                op2_sel = op2_imu;
                wb_sel  = wb_alu;
            end
            opc_auipc: begin
                op1_sel = op1_pc;
                op2_sel = op2_imu;
                wb_sel  = wb_alu;
            end
            opc_jal: begin
                op1_sel = op1_pc;
                op2_sel = op2_imj;
                wb_sel  = wb_link;
                is_jal  = 1'b1;
            end
            opc_jalr: begin
                op1_sel = op1_rs1;
                wb_sel  = wb_link;
                use_rs1 = 1'b1;
                is_jalr = 1'b1;
                illegal = (funct3 != 3'b000);
            end
            opc_branch: begin
                op1_sel   = op1_rs1;
                op2_sel   = op2_rs2;
                use_rs1   = 1'b1;
                use_rs2   = 1'b1;
                is_branch = 1'b1;
                case (funct3)
                    3'b000:  alu_op = br_beq;
                    3'b001:  alu_op = br_bne;
                    3'b100:  alu_op = br_blt;
                    3'b101:  alu_op = br_bge;
                    3'b110:  alu_op = br_bltu;
                    3'b111:  alu_op = br_bgeu;
                    default: illegal = 1'b1;
                endcase
            end
            opc_op_imm: begin
                op1_sel = op1_rs1;
                wb_sel  = wb_alu;
                use_rs1 = 1'b1;
                case (funct3)
                    3'b000: alu_op = alu_add;
                    3'b010: alu_op = alu_slt;
                    3'b011: alu_op = alu_sltu;
                    3'b100: alu_op = alu_xor;
                    3'b110: alu_op = alu_or;
                    3'b111: alu_op = alu_and;
                    3'b001: begin
                        alu_op  = alu_sll;
                        illegal = (funct7 != 7'b0000000);
                    end
                    default: begin  // srli / srai
                        alu_op  = funct7[5] ? alu_sra : alu_srl;
                        illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
                    end
                endcase
            end
            opc_op: begin
                op1_sel = op1_rs1;
                op2_sel = op2_rs2;
                wb_sel  = wb_alu;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: alu_op = alu_add;
                    10'b0100000_000: alu_op = alu_sub;
                    10'b0000000_001: alu_op = alu_sll;
                    10'b0000000_010: alu_op = alu_slt;
                    10'b0000000_011: alu_op = alu_sltu;
                    10'b0000000_100: alu_op = alu_xor;
                    10'b0000000_101: alu_op = alu_srl;
                    10'b0100000_101: alu_op = alu_sra;
                    10'b0000000_110: alu_op = alu_or;
                    10'b0000000_111: alu_op = alu_and;
                    default:         illegal = 1'b1;
                endcase
            end
            default: illegal = 1'b1;  // load, store, system, unknown
        endcase
        if (illegal) begin
            op1_sel   = op1_zero;
            wb_sel    = wb_none;
            use_rs1   = 1'b0;
            use_rs2   = 1'b0;
            is_branch = 1'b0;
            is_jal    = 1'b0;
            is_jalr   = 1'b0;
        end
    end

    assign rf.rs1_addr = rs1;
    assign rf.rs2_addr = rs2;

    // raw hazard against the two older instructions
    assign stall = (use_rs1 && rs1 != '0 &&
                    ((pend_a_valid && pend_a_rd == rs1) || (pend_b_valid && pend_b_rd == rs1)))
                || (use_rs2 && rs2 != '0 &&
                    ((pend_a_valid && pend_a_rd == rs2) || (pend_b_valid && pend_b_rd == rs2)));

    assign in_ready  = out_ready && !stall;
    assign out_valid = in_valid && !stall;

    always_comb begin
        out_pkt.pc = in_pc;
        case (op1_sel)
            op1_rs1: out_pkt.op1 = rf.rs1_data;
            op1_pc:  out_pkt.op1 = in_pc;
            default: out_pkt.op1 = '0;
        endcase
        case (op2_sel)
            op2_rs2: out_pkt.op2 = rf.rs2_data;
            op2_imj: out_pkt.op2 = imm_j;
            op2_imu: out_pkt.op2 = imm_u;
            default: out_pkt.op2 = imm_i;
        endcase
        out_pkt.rs2_val   = rf.rs2_data;
        out_pkt.br_off    = is_jal ? imm_j : imm_b;
        out_pkt.alu_op    = alu_op;
        out_pkt.wb_sel    = wb_sel;
        out_pkt.rd        = in_inst[11:7];
        out_pkt.is_branch = is_branch;
        out_pkt.is_jal    = is_jal;
        out_pkt.is_jalr   = is_jalr;
        out_pkt.illegal   = illegal;
    end

endmodule

`default_nettype wire

// File: design/rv_stage_reg.sv
`default_nettype none

module rv_stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic     full;
    payload_t data_q;

    // free slot, or the held entry leaves this cycle
    assign in_ready = !full || out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b0;
        end else if (in_ready) begin
            full <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            data_q <= in_data;
        end
    end

    assign out_valid = full;
    assign out_data  = data_q;

    a_hold_stable: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

`default_nettype wire

// File: design/rv_regfile.sv
`default_nettype none

`include "rv_macros.svh"

module rv_regfile (
    input  logic                  clk,
    input  logic                  rst,
    rv_rf_read_if.bank            rd,
    input  logic                  wen,
    input  logic [`RV_REG_AW-1:0] waddr,
    input  logic [`RV_XLEN-1:0]   wdata
);

    logic [`RV_XLEN-1:0] regs [1:`RV_NUM_REGS-1];  // x0 has no storage

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rd.rs1_data = (rd.rs1_addr == '0) ? '0 : regs[rd.rs1_addr];
    assign rd.rs2_data = (rd.rs2_addr == '0) ? '0 : regs[rd.rs2_addr];

    // writeback filters rd == 0 before it gets here
    a_no_x0_write: assert property (@(posedge clk) disable iff (rst)
        wen |-> waddr != '0);

endmodule

`default_nettype wire

// File: design/rv_rf_read_if.sv
`default_nettype none

`include "rv_macros.svh"

interface rv_rf_read_if;
    logic [`RV_REG_AW-1:0] rs1_addr;
    logic [`RV_REG_AW-1:0] rs2_addr;
    logic [`RV_XLEN-1:0]   rs1_data;
    logic [`RV_XLEN-1:0]   rs2_data;

    modport reader (output rs1_addr, output rs2_addr, input rs1_data, input rs2_data);
    modport bank (input rs1_addr, input rs2_addr, output rs1_data, output rs2_data);
endinterface

`default_nettype wire

// File: design/rv_pkg.sv
`default_nettype none

`include "rv_macros.svh"

package rv_pkg;

    typedef enum logic [4:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_slt,
        alu_sltu,
        alu_copy2,  // passes op2, used by lui
        br_beq,
        br_bne,
        br_blt,
        br_bge,
        br_bltu,
        br_bgeu
    } alu_op_e;

    typedef enum logic [1:0] {
        op1_rs1,
        op1_pc,
        op1_zero
    } op1_sel_e;

    typedef enum logic [1:0] {
        op2_rs2,
        op2_imi,
        op2_imj,
        op2_imu
    } op2_sel_e;

    typedef enum logic [1:0] {
        wb_none,
        wb_alu,
        wb_link  // pc+4 of a jump
    } wb_sel_e;

    typedef struct packed {
        logic [`RV_XLEN-1:0]   pc;
        logic [`RV_XLEN-1:0]   op1;
        logic [`RV_XLEN-1:0]   op2;
        logic [`RV_XLEN-1:0]   rs2_val;  // branch compare operand
        logic [`RV_XLEN-1:0]   br_off;   // b or j immediate
        alu_op_e               alu_op;
        wb_sel_e               wb_sel;
        logic [`RV_REG_AW-1:0] rd;
        logic                  is_branch;
        logic                  is_jal;
        logic                  is_jalr;
        logic                  illegal;
    } dec_pkt_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0]   pc;
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_XLEN-1:0]   value;
        logic                  rd_wen;
        logic                  branch_taken;
        logic [`RV_XLEN-1:0]   next_pc;
        logic                  illegal;
    } exe_pkt_t;

endpackage

`default_nettype wire

// File: design/rv_macros.svh
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// datapath word width
`define RV_XLEN 32

// architectural register count, x0 included
`define RV_NUM_REGS 32

// register index width
`define RV_REG_AW 5

`endif
